// File: build.f
+incdir+src
src/sdram_pkg.sv
src/sdram_init.sv
src/sdram_write.sv
src/sdram_read.sv
src/sdram_arbiter.sv
src/sdram_ctrl.sv
sim/clk_gen.sv
sim/tb_sdram_ctrl.sv

// File: run.sh
#!/bin/sh
# build and run the SDRAM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_sdram_ctrl -f build.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_sdram_ctrl)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qF "*** PASSED ***"; then
   exit 0
fi
exit 1

// File: sim/clk_gen.sv
module clk_gen (
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period
   end

   initial begin
      rst_n = 1'b1;
      #1 rst_n = 1'b0;   // edge for the async reset before the first clock
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

// File: sim/tb_sdram_ctrl.sv
`include "sdram_params.svh"

module tb_sdram_ctrl;
   timeunit 1ns;
   timeprecision 100ps;

   typedef struct packed {
      logic        is_write;
      logic [23:0] addr;
      logic [3:0]  len;
      logic [63:0] data;
   } stim_t;

   localparam int NUM_STIM = 24;   // write, read, 8-byte read for each len
   localparam int INIT_CYC = `SDRAM_INIT_WAIT + `SDRAM_TRP_CLK + 2 * `SDRAM_TRFC_CLK + 3 + 8;
   localparam int TXN_CYC  = 6 + `SDRAM_TRCD_CLK + 8 + 2 + `SDRAM_TRP_CLK + 4;
   localparam int LIMIT    = INIT_CYC + (NUM_STIM + 3) * TXN_CYC * 2;

   logic                  clk;
   logic                  rst_n;
   logic                  wr_req;
   sdram_pkg::mem_req_t   wr_cmd;
   logic [63:0]           wr_data;
   logic                  wr_end;
   logic                  rd_req;
   sdram_pkg::mem_req_t   rd_cmd;
   logic [63:0]           rd_data;
   logic                  rd_end;
   logic                  init_done;
   sdram_pkg::sdram_bus_t bus;
   logic [7:0]            dq_out;
   logic                  dq_oe;
   logic [7:0]            dq_in = 8'hee;

   // device model state
   logic [7:0]            mem [logic [23:0]];
   logic [7:0]            ref_mem [logic [23:0]];
   logic [12:0]           open_row [4];
   sdram_pkg::sdram_bus_t log_bus [$];   // non-NOP ops in issue order
   int                    log_cyc [$];
   int                    cyc = 0;
   int                    end_cyc = 0;
   logic                  wr_on = 1'b0;
   logic [23:0]           wr_addr = '0;
   logic                  rd_on = 1'b0;
   int                    rd_wait = 0;
   int                    rd_left = 0;   // -1 while no stop seen
   logic [23:0]           rd_addr = '0;

   stim_t                 tbl [NUM_STIM];
   integer                seed;

   clk_gen u_clk (
      .clk  (clk),
      .rst_n(rst_n)
   );

   sdram_ctrl dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_req   (wr_req),
      .wr_cmd   (wr_cmd),
      .wr_data  (wr_data),
      .wr_end   (wr_end),
      .rd_req   (rd_req),
      .rd_cmd   (rd_cmd),
      .rd_data  (rd_data),
      .rd_end   (rd_end),
      .init_done(init_done),
      .bus      (bus),
      .dq_out   (dq_out),
      .dq_oe    (dq_oe),
      .dq_in    (dq_in)
   );

   function automatic logic [7:0] fill_byte(input logic [23:0] a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'ha5;
   endfunction

   function automatic logic [7:0] dev_byte(input logic [23:0] a);
      return mem.exists(a) ? mem[a] : fill_byte(a);
   endfunction

   function automatic logic [7:0] ref_byte(input logic [23:0] a);
      return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
   endfunction

   // column wraps inside the open page
   function automatic logic [23:0] next_col(input logic [23:0] a);
      return {a[23:9], a[8:0] + 9'd1};
   endfunction

   task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
      if (got !== exp) begin
         $display("FAILED time %0d ns: %s, got %h expected %h", $time, what, got, exp);
         $display("*** FAILED ***");
         $fatal(1, "mismatch");
      end
   endtask

   // behavioral SDRAM, samples the bus on each rising edge
   always @(posedge clk) begin
      cyc = cyc + 1;
      dq_in <= 8'hee;   // junk while no burst is out
      if (wr_end || rd_end) end_cyc = cyc;
      if (rst_n) begin
         if (rd_on) begin
            if (rd_wait > 0) begin
               rd_wait = rd_wait - 1;
            end else if (rd_left != 0) begin
               dq_in <= dev_byte(rd_addr);
               rd_addr = next_col(rd_addr);
               if (rd_left > 0) rd_left = rd_left - 1;
            end else begin
               rd_on = 1'b0;
            end
         end
         if (bus.op != sdram_pkg::NOP) begin
            log_bus.push_back(bus);
            log_cyc.push_back(cyc);
         end
         case (bus.op)
            sdram_pkg::ACTIVE: open_row[bus.ba] = bus.addr;
            sdram_pkg::WRITE: begin
               wr_on   = 1'b1;
               wr_addr = {bus.ba, open_row[bus.ba], bus.addr[8:0]};
            end
            sdram_pkg::READ: begin
               rd_on   = 1'b1;
               rd_wait = `SDRAM_CAS_LATENCY - 2;   // data lands CL edges later
               rd_left = -1;
               rd_addr = {bus.ba, open_row[bus.ba], bus.addr[8:0]};
            end
            sdram_pkg::BURST_TERM, sdram_pkg::PRECHARGE: begin
               wr_on = 1'b0;
               if (rd_on && rd_left < 0) rd_left = `SDRAM_CAS_LATENCY - 2;   // CL-1 beats remain
            end
            default: ;
         endcase
         if (wr_on && dq_oe) begin
            mem[wr_addr] = dq_out;
            wr_addr = next_col(wr_addr);
         end
      end
   end

   task automatic build_table();
      logic [31:0] base;
      logic [31:0] hi;
      logic [31:0] lo;
      logic [23:0] a;
      int n;
      for (n = 1; n <= 8; n++) begin
         base = $random(seed);
         hi   = $random(seed);
         lo   = $random(seed);
         a    = {base[23:9], 1'b0, base[7:0]};   // column stays clear of the page end
         tbl[3*n-3] = '{is_write: 1'b1, addr: a, len: 4'(n), data: {hi, lo}};
         tbl[3*n-2] = '{is_write: 1'b0, addr: a, len: 4'(n), data: 64'd0};
         tbl[3*n-1] = '{is_write: 1'b0, addr: a, len: 4'd8, data: 64'd0};
      end
   endtask

   // last four logged ops belong to the transaction just ended
   task automatic check_txn(input stim_t s);
      int n;
      sdram_pkg::sdram_bus_t act;
      sdram_pkg::sdram_bus_t cmd;
      sdram_pkg::sdram_bus_t bt;
      sdram_pkg::sdram_bus_t pre;
      sdram_pkg::sdram_op_t  rw_op;
      n = log_bus.size();
      check_eq(64'(n >= 4), 64'd1, "fewer than four commands logged");
      act   = log_bus[n-4];
      cmd   = log_bus[n-3];
      bt    = log_bus[n-2];
      pre   = log_bus[n-1];
      rw_op = s.is_write ? sdram_pkg::WRITE : sdram_pkg::READ;
      check_eq(64'(act.op), 64'(sdram_pkg::ACTIVE), "first command is not ACTIVE");
      check_eq(64'({act.ba, act.addr}), 64'(s.addr[23:9]), "ACTIVE bank or row");
      check_eq(64'(cmd.op), 64'(rw_op), "second command is not the access");
      check_eq(64'({cmd.ba, cmd.addr}), 64'({s.addr[23:22], 4'b0000, s.addr[8:0]}),
               "access bank or column");
      check_eq(64'(log_cyc[n-3] - log_cyc[n-4] >= `SDRAM_TRCD_CLK), 64'd1, "tRCD too short");
      check_eq(64'(bt.op), 64'(sdram_pkg::BURST_TERM), "third command is not BURST_TERM");
      check_eq(64'(log_cyc[n-2] - log_cyc[n-3]), 64'(s.len), "BURST_TERM spacing");
      check_eq(64'(pre.op), 64'(sdram_pkg::PRECHARGE), "fourth command is not PRECHARGE");
      check_eq(64'(pre.addr[10]), 64'd0, "PRECHARGE with A10 high");
      check_eq(64'(pre.ba), 64'(s.addr[23:22]), "PRECHARGE bank");
      check_eq(64'(end_cyc - log_cyc[n-1] >= `SDRAM_TRP_CLK), 64'd1, "tRP too short");
   endtask

   task automatic run_txn(input stim_t s);
      logic [63:0] got;
      logic [63:0] exp;
      int len;
      int k;
      len = int'(s.len);
      got = '0;
      exp = '0;
      @(posedge clk);
      if (s.is_write) begin
         wr_cmd  <= '{addr: s.addr, len: s.len};
         wr_data <= s.data;
         wr_req  <= 1'b1;
         do @(posedge clk); while (!wr_end);
         wr_req <= 1'b0;
         for (k = 0; k < len; k++) ref_mem[s.addr + 24'(k)] = s.data[8*k +: 8];
      end else begin
         for (k = 0; k < len; k++) exp[8*k +: 8] = ref_byte(s.addr + 24'(k));
         rd_cmd <= '{addr: s.addr, len: s.len};
         rd_req <= 1'b1;
         do @(posedge clk); while (!rd_end);
         rd_req <= 1'b0;
         got = rd_data;
      end
      @(negedge clk);
      if (!s.is_write) check_eq(got, exp, $sformatf("read at %h len %0d", s.addr, len));
      check_txn(s);
   endtask

   // read and write raised together, read goes first
   task automatic tie_test();
      logic [23:0] a;
      logic [63:0] new_data;
      logic [63:0] old_exp;
      logic [63:0] got_rd;
      logic        rd_seen;
      logic        wr_seen;
      int          rd_at;
      int          wr_at;
      int          n;
      int          k;
      a        = tbl[NUM_STIM-3].addr;
      new_data = {$random(seed), $random(seed)};
      for (k = 0; k < 8; k++) old_exp[8*k +: 8] = ref_byte(a + 24'(k));
      rd_seen = 1'b0;
      wr_seen = 1'b0;
      rd_at   = 0;
      wr_at   = 0;
      n       = 0;
      got_rd  = '0;
      @(posedge clk);
      wr_cmd  <= '{addr: a, len: 4'd8};
      wr_data <= new_data;
      rd_cmd  <= '{addr: a, len: 4'd8};
      wr_req  <= 1'b1;
      rd_req  <= 1'b1;
      while (!(rd_seen && wr_seen)) begin
         @(posedge clk);
         n++;
         if (rd_end) begin
            rd_req  <= 1'b0;
            rd_seen = 1'b1;
            rd_at   = n;
            got_rd  = rd_data;
         end
         if (wr_end) begin
            wr_req  <= 1'b0;
            wr_seen = 1'b1;
            wr_at   = n;
         end
      end
      check_eq(64'(rd_at < wr_at), 64'd1, "write served before read on a tie");
      check_eq(got_rd, old_exp, "tie read did not return old contents");
      for (k = 0; k < 8; k++) ref_mem[a + 24'(k)] = new_data[8*k +: 8];
      run_txn('{is_write: 1'b0, addr: a, len: 4'd8, data: 64'd0});
   endtask

   // power-up command order, checked once init_done is seen
   initial begin
      do @(posedge clk); while (!init_done);
      @(negedge clk);
      check_eq(64'(log_bus.size()), 64'd4, "init issued other than four commands");
      check_eq(64'(log_bus[0].op), 64'(sdram_pkg::PRECHARGE), "init command 0");
      check_eq(64'(log_bus[0].addr[10]), 64'd1, "init PRECHARGE without A10");
      check_eq(64'(log_bus[1].op), 64'(sdram_pkg::AUTO_REFRESH), "init command 1");
      check_eq(64'(log_bus[2].op), 64'(sdram_pkg::AUTO_REFRESH), "init command 2");
      check_eq(64'(log_bus[3].op), 64'(sdram_pkg::LOAD_MODE), "init command 3");
      check_eq(64'(log_bus[3].addr[6:4]), 64'(`SDRAM_CAS_LATENCY), "mode word CAS latency");
      check_eq(64'(log_bus[3].addr[2:0]), 64'h7, "mode word burst length");
   end

   initial begin
      repeat (LIMIT) @(posedge clk);
      $display("timeout: run did not finish within %0d clock cycles", LIMIT);
      $display("*** FAILED ***");
      $fatal(1, "watchdog expired");
   end

   initial begin
      seed    = 32'h28eb06d8;
      wr_req  = 1'b0;
      rd_req  = 1'b0;
      wr_cmd  = '0;
      rd_cmd  = '0;
      wr_data = '0;
      build_table();
      @(posedge clk);   // still in reset
      check_eq(64'(bus), 64'(sdram_pkg::BUS_IDLE), "bus not idle in reset");
      check_eq(64'(dq_oe), 64'd0, "dq_oe high in reset");
      check_eq(64'(init_done), 64'd0, "init_done high in reset");
      check_eq(64'({wr_end, rd_end}), 64'd0, "end pulse in reset");
      // entry 0 raises wr_req while init is still running
      for (int i = 0; i < NUM_STIM; i++) run_txn(tbl[i]);
      tie_test();
      repeat (2) @(posedge clk);
      $display("*** PASSED ***");
      $finish;
   end

endmodule

// File: src/sdram_arbiter.sv
module sdram_arbiter (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  init_done,
   input  logic                  wr_req,
   input  logic                  rd_req,
   input  sdram_pkg::sdram_bus_t init_bus,
   input  sdram_pkg::sdram_bus_t wr_bus,
   input  sdram_pkg::sdram_bus_t rd_bus,
   input  logic [7:0]            wr_dq,
   input  logic                  wr_oe,
   input  logic                  wr_done,
   input  logic                  rd_done,
   output logic                  wr_start,
   output logic                  rd_start,
   output sdram_pkg::sdram_bus_t bus,
   output logic [7:0]            dq_out,
   output logic                  dq_oe
);

   localparam logic [1:0]
      OWN_INIT  = 2'd0,
      OWN_IDLE  = 2'd1,
      OWN_WRITE = 2'd2,
      OWN_READ  = 2'd3;

   logic [1:0]            owner;
   sdram_pkg::sdram_bus_t bus_sel;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         owner    <= OWN_INIT;
         wr_start <= 1'b0;
         rd_start <= 1'b0;
      end else begin
         wr_start <= 1'b0;   // strobes last one cycle
         rd_start <= 1'b0;
         case (owner)
            OWN_INIT: if (init_done) owner <= OWN_IDLE;
            OWN_IDLE: begin
               if (rd_req) begin   // read wins a tie
                  owner    <= OWN_READ;
                  rd_start <= 1'b1;
               end else if (wr_req) begin
                  owner    <= OWN_WRITE;
                  wr_start <= 1'b1;
               end
            end
            OWN_WRITE: if (wr_done) owner <= OWN_IDLE;
            default: if (rd_done) owner <= OWN_IDLE;
         endcase
      end
   end

   always_comb begin
      case (owner)
         OWN_INIT:  bus_sel = init_bus;
         OWN_WRITE: bus_sel = wr_bus;
         OWN_READ:  bus_sel = rd_bus;
         default:   bus_sel = sdram_pkg::BUS_IDLE;
      endcase
   end

   // output register toward the pins
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bus    <= sdram_pkg::BUS_IDLE;
         dq_out <= '0;
         dq_oe  <= 1'b0;
      end else begin
         bus    <= bus_sel;
         dq_out <= (owner == OWN_WRITE) ? wr_dq : 8'h00;
         dq_oe  <= (owner == OWN_WRITE) && wr_oe;
      end
   end

endmodule

// File: src/sdram_ctrl.sv
module sdram_ctrl (
   input  logic                  clk,
   input  logic                  rst_n,
   // write port
   input  logic                  wr_req,
   input  sdram_pkg::mem_req_t   wr_cmd,
   input  logic [63:0]           wr_data,
   output logic                  wr_end,
   // read port
   input  logic                  rd_req,
   input  sdram_pkg::mem_req_t   rd_cmd,
   output logic [63:0]           rd_data,
   output logic                  rd_end,
   output logic                  init_done,
   // device side
   output sdram_pkg::sdram_bus_t bus,
   output logic [7:0]            dq_out,
   output logic                  dq_oe,
   input  logic [7:0]            dq_in
);

   sdram_pkg::sdram_bus_t init_bus;
   sdram_pkg::sdram_bus_t wr_bus;
   sdram_pkg::sdram_bus_t rd_bus;
   logic [7:0]            wr_dq;
   logic                  wr_oe;
   logic                  wr_start;
   logic                  rd_start;

   sdram_init u_init (
      .clk  (clk),
      .rst_n(rst_n),
      .bus  (init_bus),
      .done (init_done)
   );

   sdram_arbiter u_arbiter (
      .clk      (clk),
      .rst_n    (rst_n),
      .init_done(init_done),
      .wr_req   (wr_req),
      .rd_req   (rd_req),
      .init_bus (init_bus),
      .wr_bus   (wr_bus),
      .rd_bus   (rd_bus),
      .wr_dq    (wr_dq),
      .wr_oe    (wr_oe),
      .wr_done  (wr_end),
      .rd_done  (rd_end),
      .wr_start (wr_start),
      .rd_start (rd_start),
      .bus      (bus),
      .dq_out   (dq_out),
      .dq_oe    (dq_oe)
   );

   sdram_write u_write (
      .clk   (clk),
      .rst_n (rst_n),
      .start (wr_start),
      .req   (wr_cmd),
      .wdata (wr_data),
      .bus   (wr_bus),
      .dq_out(wr_dq),
      .dq_oe (wr_oe),
      .done  (wr_end)
   );

   sdram_read u_read (
      .clk  (clk),
      .rst_n(rst_n),
      .start(rd_start),
      .req  (rd_cmd),
      .dq_in(dq_in),
      .bus  (rd_bus),
      .rdata(rd_data),
      .done (rd_end)
   );

endmodule

// File: src/sdram_init.sv
`include "sdram_params.svh"

module sdram_init (
   input  logic                  clk,
   input  logic                  rst_n,
   output sdram_pkg::sdram_bus_t bus,
   output logic                  done
);

   localparam logic [15:0] WAIT_LAST = 16'(`SDRAM_INIT_WAIT - 1);
   localparam logic [15:0] TRP_LAST  = 16'(`SDRAM_TRP_CLK - 1);
   localparam logic [15:0] TRFC_LAST = 16'(`SDRAM_TRFC_CLK - 1);
   localparam logic [2:0]  MR_CL     = 3'(`SDRAM_CAS_LATENCY);

   localparam logic [2:0]
      ST_POWER_WAIT = 3'd0,
      ST_PRECHARGE  = 3'd1,
      ST_TRP_WAIT   = 3'd2,
      ST_REFRESH    = 3'd3,
      ST_TRFC_WAIT  = 3'd4,
      ST_MODE       = 3'd5,
      ST_MODE_WAIT  = 3'd6,
      ST_DONE       = 3'd7;

   logic [2:0]  state;
   logic [15:0] cnt;
   logic        second_ref;   // second refresh already issued

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= ST_POWER_WAIT;
         cnt        <= '0;
         second_ref <= 1'b0;
      end else begin
         case (state)
            ST_POWER_WAIT: begin
               if (cnt == WAIT_LAST) begin
                  state <= ST_PRECHARGE;
                  cnt   <= '0;
               end else begin
                  cnt <= cnt + 16'd1;
               end
            end
            ST_PRECHARGE: state <= ST_TRP_WAIT;
            ST_TRP_WAIT: begin
               if (cnt == TRP_LAST) begin
                  state <= ST_REFRESH;
                  cnt   <= '0;
               end else begin
                  cnt <= cnt + 16'd1;
               end
            end
            ST_REFRESH: state <= ST_TRFC_WAIT;
            ST_TRFC_WAIT: begin
               if (cnt == TRFC_LAST) begin
                  cnt        <= '0;
                  second_ref <= 1'b1;
                  state      <= second_ref ? ST_MODE : ST_REFRESH;
               end else begin
                  cnt <= cnt + 16'd1;
               end
            end
            ST_MODE: state <= ST_MODE_WAIT;
            ST_MODE_WAIT: begin
               // tMRD of two cycles
               if (cnt == 16'd1) begin
                  state <= ST_DONE;
               end else begin
                  cnt <= cnt + 16'd1;
               end
            end
            default: state <= ST_DONE;   // stays here until reset
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bus  <= sdram_pkg::BUS_IDLE;
         done <= 1'b0;
      end else begin
         done <= (state == ST_DONE);
         case (state)
            ST_PRECHARGE: begin
               bus <= '{op: sdram_pkg::PRECHARGE, ba: 2'b11, addr: 13'h0400};   // A10 all banks
            end
            ST_REFRESH: begin
               bus <= '{op: sdram_pkg::AUTO_REFRESH, ba: 2'b11, addr: 13'h1fff};
            end
            ST_MODE: begin
               // CL in [6:4], sequential, full page in [2:0]
               bus <= '{op: sdram_pkg::LOAD_MODE, ba: 2'b00,
                        addr: {6'b000000, MR_CL, 1'b0, 3'b111}};
            end
            default: bus <= sdram_pkg::BUS_IDLE;
         endcase
      end
   end

endmodule

// File: src/sdram_params.svh
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

// system clock
`define SDRAM_CLK_HZ      100_000_000

// device timing in ns
`define SDRAM_TRCD_NS     20   // active to read/write
`define SDRAM_TRP_NS      20   // precharge period
`define SDRAM_TRFC_NS     70   // auto refresh period

// mode register, 2 or 3
`define SDRAM_CAS_LATENCY 2

// power-up wait in cycles, short for simulation
`define SDRAM_INIT_WAIT   20

// clock period in ns
`define SDRAM_CLK_NS      (1_000_000_000 / `SDRAM_CLK_HZ)

// waits rounded up to whole cycles
`define SDRAM_TRCD_CLK    ((`SDRAM_TRCD_NS + `SDRAM_CLK_NS - 1) / `SDRAM_CLK_NS)
`define SDRAM_TRP_CLK     ((`SDRAM_TRP_NS + `SDRAM_CLK_NS - 1) / `SDRAM_CLK_NS)
`define SDRAM_TRFC_CLK    ((`SDRAM_TRFC_NS + `SDRAM_CLK_NS - 1) / `SDRAM_CLK_NS)

`endif

// File: src/sdram_pkg.sv
package sdram_pkg;

   // command pins {cs_n, ras_n, cas_n, we_n}
   typedef enum logic [3:0] {
      LOAD_MODE    = 4'b0000,
      AUTO_REFRESH = 4'b0001,
      PRECHARGE    = 4'b0010,
      ACTIVE       = 4'b0011,
      WRITE        = 4'b0100,
      READ         = 4'b0101,
      BURST_TERM   = 4'b0110,
      NOP          = 4'b0111
   } sdram_op_t;

   // everything the device sees on one command cycle
   typedef struct packed {
      sdram_op_t   op;
      logic [1:0]  ba;     // bank select
      logic [12:0] addr;   // row, column or mode word
   } sdram_bus_t;

   // one access request from the user side
   typedef struct packed {
      logic [23:0] addr;   // bank [23:22], row [21:9], column [8:0]
      logic [3:0]  len;    // 1 to 8 bytes
   } mem_req_t;

   // bus value between commands
   localparam sdram_bus_t BUS_IDLE = '{
      op:   NOP,
      ba:   2'b11,
      addr: 13'h1fff
   };

endpackage

// File: src/sdram_read.sv
`include "sdram_params.svh"

module sdram_read (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start,   // one-cycle grant
   input  sdram_pkg::mem_req_t   req,
   input  logic [7:0]            dq_in,
   output sdram_pkg::sdram_bus_t bus,
   output logic [63:0]           rdata,
   output logic                  done
);

   localparam logic [3:0] TRCD_LAST = 4'(`SDRAM_TRCD_CLK - 1);
   localparam logic [3:0] TRP_LAST  = 4'(`SDRAM_TRP_CLK - 1);
   // engine register, arbiter register, then CAS latency
   localparam int CAP_DEPTH = `SDRAM_CAS_LATENCY + 2;

   localparam logic [2:0]
      ST_IDLE           = 3'b000,
      ST_ACTIVE         = 3'b001,
      ST_ACTIVE_WAIT    = 3'b011,
      ST_READ           = 3'b010,
      ST_BURST_TERM     = 3'b110,
      ST_PRECHARGE      = 3'b111,
      ST_PRECHARGE_WAIT = 3'b101,
      ST_DONE           = 3'b100;

   logic [2:0]           state;
   logic [3:0]           cnt;
   logic [CAP_DEPTH-1:0] rd_pipe;   // READ issue walking toward byte 0
   logic                 cap_on;    // bytes 1 and up still due
   logic [3:0]           cap_cnt;
   logic                 cap_en;
   logic [1:0]           bank;
   logic [12:0]          row;
   logic [12:0]          col;

   assign bank   = req.addr[23:22];
   assign row    = req.addr[21:9];
   assign col    = {4'b0000, req.addr[8:0]};
   assign cap_en = rd_pipe[CAP_DEPTH-1] | cap_on;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            ST_IDLE: if (start) state <= ST_ACTIVE;
            ST_ACTIVE: begin
               state <= ST_ACTIVE_WAIT;
               cnt   <= '0;
            end
            ST_ACTIVE_WAIT: begin
               if (cnt == TRCD_LAST) begin
                  state <= ST_READ;
                  cnt   <= '0;
               end else begin
                  cnt <= cnt + 4'd1;
               end
            end
            ST_READ: begin
               if (cnt == req.len - 4'd1) state <= ST_BURST_TERM;   // stop after len beats
               else cnt <= cnt + 4'd1;
            end
            ST_BURST_TERM: state <= ST_PRECHARGE;
            ST_PRECHARGE: begin
               state <= ST_PRECHARGE_WAIT;
               cnt   <= '0;
            end
            ST_PRECHARGE_WAIT: begin
               if (cnt == TRP_LAST) state <= ST_DONE;
               else cnt <= cnt + 4'd1;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bus  <= sdram_pkg::BUS_IDLE;
         done <= 1'b0;
      end else begin
         done <= (state == ST_DONE);
         case (state)
            ST_ACTIVE: bus <= '{op: sdram_pkg::ACTIVE, ba: bank, addr: row};
            ST_READ: begin
               if (cnt == 4'd0) bus <= '{op: sdram_pkg::READ, ba: bank, addr: col};
               else bus <= sdram_pkg::BUS_IDLE;
            end
            ST_BURST_TERM: bus <= '{op: sdram_pkg::BURST_TERM, ba: 2'b11, addr: 13'h1fff};
            ST_PRECHARGE: bus <= '{op: sdram_pkg::PRECHARGE, ba: bank, addr: 13'h0000};
            default: bus <= sdram_pkg::BUS_IDLE;
         endcase
      end
   end

   // capture counter, started CAS latency after READ reaches the device
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_pipe <= '0;
         cap_on  <= 1'b0;
         cap_cnt <= '0;
      end else begin
         rd_pipe <= {rd_pipe[CAP_DEPTH-2:0], (state == ST_READ) && (cnt == 4'd0)};
         if (start) begin
            cap_on  <= 1'b0;
            cap_cnt <= '0;
         end else if (cap_en) begin
            cap_cnt <= cap_cnt + 4'd1;
            cap_on  <= (cap_cnt + 4'd1) < req.len;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) rdata <= '0;
      else if (start) rdata <= '0;   // bytes beyond len stay zero
      else if (cap_en) rdata[cap_cnt[2:0]*8 +: 8] <= dq_in;
   end

endmodule

// File: src/sdram_write.sv
`include "sdram_params.svh"

module sdram_write (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start,   // one-cycle grant
   input  sdram_pkg::mem_req_t   req,
   input  logic [63:0]           wdata,
   output sdram_pkg::sdram_bus_t bus,
   output logic [7:0]            dq_out,
   output logic                  dq_oe,
   output logic                  done
);

   localparam logic [3:0] TRCD_LAST = 4'(`SDRAM_TRCD_CLK - 1);
   localparam logic [3:0] TRP_LAST  = 4'(`SDRAM_TRP_CLK - 1);

   localparam logic [2:0]
      ST_IDLE           = 3'b000,
      ST_ACTIVE         = 3'b001,
      ST_ACTIVE_WAIT    = 3'b011,
      ST_WRITE          = 3'b010,
      ST_BURST_TERM     = 3'b110,
      ST_PRECHARGE      = 3'b111,
      ST_PRECHARGE_WAIT = 3'b101,
      ST_DONE           = 3'b100;

   logic [2:0]  state;
   logic [3:0]  cnt;    // wait cycles, then data beat
   logic [1:0]  bank;
   logic [12:0] row;
   logic [12:0] col;

   assign bank = req.addr[23:22];
   assign row  = req.addr[21:9];
   assign col  = {4'b0000, req.addr[8:0]};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            ST_IDLE: if (start) state <= ST_ACTIVE;
            ST_ACTIVE: begin
               state <= ST_ACTIVE_WAIT;
               cnt   <= '0;
            end
            ST_ACTIVE_WAIT: begin
               if (cnt == TRCD_LAST) begin
                  state <= ST_WRITE;
                  cnt   <= '0;
               end else begin
                  cnt <= cnt + 4'd1;
               end
            end
            ST_WRITE: begin
               if (cnt == req.len - 4'd1) begin
                  state <= ST_BURST_TERM;
               end else begin
                  cnt <= cnt + 4'd1;
               end
            end
            ST_BURST_TERM: state <= ST_PRECHARGE;
            ST_PRECHARGE: begin
               state <= ST_PRECHARGE_WAIT;
               cnt   <= '0;
            end
            ST_PRECHARGE_WAIT: begin
               if (cnt == TRP_LAST) state <= ST_DONE;
               else cnt <= cnt + 4'd1;
            end
            default: state <= ST_IDLE;   // done state lasts one cycle
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bus    <= sdram_pkg::BUS_IDLE;
         dq_out <= '0;
         dq_oe  <= 1'b0;
         done   <= 1'b0;
      end else begin
         done <= (state == ST_DONE);
         case (state)
            ST_ACTIVE: bus <= '{op: sdram_pkg::ACTIVE, ba: bank, addr: row};
            ST_WRITE: begin
               if (cnt == 4'd0) bus <= '{op: sdram_pkg::WRITE, ba: bank, addr: col};
               else bus <= sdram_pkg::BUS_IDLE;   // burst continues on NOP
            end
            ST_BURST_TERM: bus <= '{op: sdram_pkg::BURST_TERM, ba: 2'b11, addr: 13'h1fff};
            ST_PRECHARGE: bus <= '{op: sdram_pkg::PRECHARGE, ba: bank, addr: 13'h0000};
            default: bus <= sdram_pkg::BUS_IDLE;
         endcase
         // beat k carries byte k, lowest first
         if (state == ST_WRITE) begin
            dq_out <= wdata[cnt[2:0]*8 +: 8];
            dq_oe  <= 1'b1;
         end else begin
            dq_out <= '0;
            dq_oe  <= 1'b0;
         end
      end
   end

endmodule
